// ==== filelist.f ====
src/hmc_flit_pkg.sv
src/hmc_axis_if.sv
src/hmc_link_startup.sv
src/hmc_req_builder.sv
src/hmc_rsp_assembler.sv
src/hmc_mem_port.sv
test/hmc_link_model.sv
test/hmc_mem_port_tb.sv

// ==== src/hmc_axis_if.sv ====
// FLIT stream interface
`timescale 1ns/1ns

interface hmc_axis_if import hmc_flit_pkg::*; ();

  // Word moves on a clock edge with valid and ready both high
  logic      valid;
  logic      ready;
  // Four FLITs, FLIT0 in the low bits
  axi_word_t data;
  // Per-FLIT valid, header and tail flags
  axi_user_t user;

  // Producer side, holds data and user while stalled
  modport source (
    output valid,
    output data,
    output user,
    input  ready
  );

  // Consumer side
  modport sink (
    input  valid,
    input  data,
    input  user,
    output ready
  );

endinterface

// ==== src/hmc_flit_pkg.sv ====
// HMC FLIT definitions
package hmc_flit_pkg;

  // ----------------------------------------------------------------------
  // Stream geometry
  // ----------------------------------------------------------------------

  // One FLIT is 128 bits, four FLITs per AXI word
  localparam int FLIT_W         = 128;
  localparam int FLITS_PER_WORD = 4;
  localparam int AXI_DATA_W     = FLIT_W * FLITS_PER_WORD;
  // Only the low 12 user bits carry flags
  localparam int AXI_USER_W     = 64;

  // User flag groups, one bit per FLIT in each group
  localparam int USER_VLD_LSB   = 0;
  localparam int USER_HDR_LSB   = 4;
  localparam int USER_TAIL_LSB  = 8;

  // Request and response field widths
  localparam int HMC_ADDR_W     = 27;
  localparam int HMC_TAG_W      = 9;
  localparam int MEM_DATA_W     = 256;
  // Block address sits above five zero bits (32-byte blocks)
  localparam int BLOCK_SHIFT    = 5;

  typedef logic [FLIT_W-1:0]     flit_t;
  typedef logic [AXI_DATA_W-1:0] axi_word_t;
  typedef logic [AXI_USER_W-1:0] axi_user_t;
  typedef logic [HMC_ADDR_W-1:0] hmc_addr_t;
  typedef logic [HMC_TAG_W-1:0]  hmc_tag_t;
  typedef logic [MEM_DATA_W-1:0] mem_data_t;

  // ----------------------------------------------------------------------
  // Packet header
  // ----------------------------------------------------------------------

  // Header occupies the low half of the first FLIT, payload follows it
  localparam int HDR_W          = 64;
  localparam int HDR_CMD_LSB    = 0;
  localparam int HDR_CMD_W      = 6;
  localparam int HDR_LNG_LSB    = 7;
  localparam int HDR_DLN_LSB    = 11;
  localparam int HDR_LNG_W      = 4;
  localparam int HDR_TAG_LSB    = 15;
  localparam int HDR_ADDR_LSB   = 24;
  localparam int HDR_ADDR_W     = 34;
  // Cube ID and reserved bits, always zero from this host
  localparam int HDR_CUB_LSB    = 58;

  typedef logic [HDR_W-1:0]     hmc_hdr_t;
  typedef logic [HDR_LNG_W-1:0] hmc_lng_t;

  // Supported request commands
  typedef enum logic [HDR_CMD_W-1:0] {
    CMD_P_WR32 = 6'b011001,
    CMD_RD32   = 6'b110001
  } hmc_cmd_t;

  // Packet lengths in FLITs, header and tail included
  localparam hmc_lng_t LNG_P_WR32 = 4'd3;
  localparam hmc_lng_t LNG_RD32   = 4'd1;
  localparam hmc_lng_t LNG_RD_RS  = 4'd3;

  // Request header, length copied into the duplicate field
  function automatic hmc_hdr_t make_header(hmc_cmd_t cmd, hmc_lng_t lng,
                                           hmc_tag_t tag, hmc_addr_t addr);
    hmc_hdr_t hdr;
    hdr = '0;
    hdr[HDR_CMD_LSB +: HDR_CMD_W]   = cmd;
    hdr[HDR_LNG_LSB +: HDR_LNG_W]   = lng;
    hdr[HDR_DLN_LSB +: HDR_LNG_W]   = lng;
    hdr[HDR_TAG_LSB +: HMC_TAG_W]   = tag;
    hdr[HDR_ADDR_LSB +: HDR_ADDR_W] = HDR_ADDR_W'({addr, {BLOCK_SHIFT{1'b0}}});
    hdr[HDR_W-1:HDR_CUB_LSB]        = '0;
    return hdr;
  endfunction

  // User word from per-FLIT valid, header and tail masks
  function automatic axi_user_t make_user(logic [FLITS_PER_WORD-1:0] vld,
                                          logic [FLITS_PER_WORD-1:0] hdr,
                                          logic [FLITS_PER_WORD-1:0] tail);
    axi_user_t user;
    user = '0;
    user[USER_VLD_LSB +: FLITS_PER_WORD]  = vld;
    user[USER_HDR_LSB +: FLITS_PER_WORD]  = hdr;
    user[USER_TAIL_LSB +: FLITS_PER_WORD] = tail;
    return user;
  endfunction

endpackage

// ==== src/hmc_link_startup.sv ====
// Link startup hold-off
`timescale 1ns/1ns

module hmc_link_startup #(
  parameter int STARTUP_WAIT_CYCLES = 256
) (
  input  logic CLK,
  input  logic RST,
  input  logic post_done_i,
  output logic link_up_o
);

  // Wide enough to hold the terminal count itself
  localparam int CNT_W = $clog2(STARTUP_WAIT_CYCLES + 1);

  logic [CNT_W-1:0] wait_cnt;
  logic             wait_done;

  assign wait_done = (wait_cnt == CNT_W'(STARTUP_WAIT_CYCLES));

  // ----------------------------------------------------------------------
  // Settle counter and sticky link-up
  // ----------------------------------------------------------------------

  always_ff @(posedge CLK) begin
    if (RST) begin
      wait_cnt  <= '0;
      link_up_o <= 1'b0;
    end else begin
      // Count initialized cycles only, keep the count if init drops
      if (post_done_i && !wait_done) begin
        wait_cnt <= wait_cnt + 1'b1;
      end
      // Once up, stays up until reset
      if (wait_done) begin
        link_up_o <= 1'b1;
      end
    end
  end

endmodule

// ==== src/hmc_mem_port.sv ====
// HMC memory port top level
`timescale 1ns/1ns

module hmc_mem_port import hmc_flit_pkg::*; #(
  parameter int STARTUP_WAIT_CYCLES = 256
) (
  input  logic      CLK,
  input  logic      RST,
  input  logic      post_done_i,
  // Transmit stream to the link controller
  output logic      tx_valid_o,
  input  logic      tx_ready_i,
  output axi_word_t tx_data_o,
  output axi_user_t tx_user_o,
  // Receive stream from the link controller
  input  logic      rx_valid_i,
  output logic      rx_ready_o,
  input  axi_word_t rx_data_i,
  input  axi_user_t rx_user_i,
  // Posted write request
  input  logic      wr_req_i,
  input  hmc_addr_t wr_addr_i,
  input  mem_data_t wr_data_i,
  output logic      wr_ready_o,
  // Read request
  input  logic      rd_req_i,
  input  hmc_addr_t rd_addr_i,
  input  hmc_tag_t  rd_tag_i,
  output logic      rd_ready_o,
  // Read response
  output mem_data_t data_o,
  output hmc_tag_t  tag_o,
  output logic      data_valid_o
);

  logic link_up;

  hmc_axis_if tx_stream ();
  hmc_axis_if rx_stream ();

  // ----------------------------------------------------------------------
  // Stream wiring to the plain ports
  // ----------------------------------------------------------------------

  assign tx_valid_o      = tx_stream.valid;
  assign tx_data_o       = tx_stream.data;
  assign tx_user_o       = tx_stream.user;
  assign tx_stream.ready = tx_ready_i;

  assign rx_stream.valid = rx_valid_i;
  assign rx_stream.data  = rx_data_i;
  assign rx_stream.user  = rx_user_i;
  assign rx_ready_o      = rx_stream.ready;

  // ----------------------------------------------------------------------
  // Blocks
  // ----------------------------------------------------------------------

  hmc_link_startup #(
    .STARTUP_WAIT_CYCLES (STARTUP_WAIT_CYCLES)
  ) link_startup_i (
    .CLK         (CLK),
    .RST         (RST),
    .post_done_i (post_done_i),
    .link_up_o   (link_up)
  );

  hmc_req_builder req_builder_i (
    .CLK        (CLK),
    .RST        (RST),
    .link_up_i  (link_up),
    .wr_req_i   (wr_req_i),
    .wr_addr_i  (wr_addr_i),
    .wr_data_i  (wr_data_i),
    .wr_ready_o (wr_ready_o),
    .rd_req_i   (rd_req_i),
    .rd_addr_i  (rd_addr_i),
    .rd_tag_i   (rd_tag_i),
    .rd_ready_o (rd_ready_o),
    .tx         (tx_stream.source)
  );

  hmc_rsp_assembler rsp_assembler_i (
    .CLK         (CLK),
    .RST         (RST),
    .rx          (rx_stream.sink),
    .rsp_data_o  (data_o),
    .rsp_tag_o   (tag_o),
    .rsp_valid_o (data_valid_o)
  );

endmodule

// ==== src/hmc_req_builder.sv ====
// HMC request builder
`timescale 1ns/1ns

module hmc_req_builder import hmc_flit_pkg::*; (
  input  logic       CLK,
  input  logic       RST,
  input  logic       link_up_i,
  // Posted write request
  input  logic       wr_req_i,
  input  hmc_addr_t  wr_addr_i,
  input  mem_data_t  wr_data_i,
  output logic       wr_ready_o,
  // Read request
  input  logic       rd_req_i,
  input  hmc_addr_t  rd_addr_i,
  input  hmc_tag_t   rd_tag_i,
  output logic       rd_ready_o,
  // Transmit stream to the link controller
  hmc_axis_if.source tx
);

  // Output word register
  logic      tx_valid_q;
  axi_word_t tx_data_q;
  axi_user_t tx_user_q;

  logic      slot_free;
  logic      wr_take;
  logic      rd_take;
  hmc_hdr_t  wr_hdr;
  hmc_hdr_t  rd_hdr;
  axi_word_t wr_word;
  axi_word_t rd_word;

  // ----------------------------------------------------------------------
  // Request acceptance
  // ----------------------------------------------------------------------

  // Register empty, or its word leaves on this edge
  assign slot_free  = !tx_valid_q || tx.ready;
  assign wr_ready_o = link_up_i && slot_free;
  // Write wins when both strobes are up
  assign rd_ready_o = link_up_i && slot_free && !wr_req_i;
  assign wr_take    = wr_req_i && wr_ready_o;
  assign rd_take    = rd_req_i && rd_ready_o;

  // ----------------------------------------------------------------------
  // Word encoding
  // ----------------------------------------------------------------------

  // Posted writes carry tag zero
  assign wr_hdr = make_header(CMD_P_WR32, LNG_P_WR32, '0, wr_addr_i);
  assign rd_hdr = make_header(CMD_RD32, LNG_RD32, rd_tag_i, rd_addr_i);

  // FLIT3 empty, zero tail in FLIT2, payload right after the header
  assign wr_word = {FLIT_W'(0), HDR_W'(0), wr_data_i, wr_hdr};
  // Single FLIT, header low and zero tail high
  assign rd_word = {(AXI_DATA_W - FLIT_W)'(0), HDR_W'(0), rd_hdr};

  // ----------------------------------------------------------------------
  // Output register
  // ----------------------------------------------------------------------

  always_ff @(posedge CLK) begin
    if (RST) begin
      tx_valid_q <= 1'b0;
    end else if (wr_take || rd_take) begin
      tx_valid_q <= 1'b1;
    end else if (tx.ready) begin
      // Accepted with nothing new behind it
      tx_valid_q <= 1'b0;
    end
  end

  // Loads only on acceptance, so a stalled word stays put
  always_ff @(posedge CLK) begin
    if (wr_take) begin
      tx_data_q <= wr_word;
      // FLITs 0..2 valid, header in 0, tail in 2
      tx_user_q <= make_user(4'b0111, 4'b0001, 4'b0100);
    end else if (rd_take) begin
      tx_data_q <= rd_word;
      // FLIT0 alone, header and tail
      tx_user_q <= make_user(4'b0001, 4'b0001, 4'b0001);
    end
  end

  assign tx.valid = tx_valid_q;
  assign tx.data  = tx_data_q;
  assign tx.user  = tx_user_q;

endmodule

// ==== src/hmc_rsp_assembler.sv ====
// HMC read response assembler
`timescale 1ns/1ns

module hmc_rsp_assembler import hmc_flit_pkg::*; (
  input  logic      CLK,
  input  logic      RST,
  // Receive stream from the link controller
  hmc_axis_if.sink  rx,
  // Reassembled read response
  output mem_data_t rsp_data_o,
  output hmc_tag_t  rsp_tag_o,
  output logic      rsp_valid_o
);

  // Payload bits carried in the first word of a spanning response
  localparam int SPAN_C_W = 2 * FLIT_W - HDR_W;
  localparam int SPAN_D_W = FLIT_W - HDR_W;

  // Which spanning placement waits for its second word
  typedef enum logic [1:0] {
    PEND_NONE,
    PEND_C,
    PEND_D
  } pend_t;

  logic                      rx_ready_q;
  logic                      rx_fire;
  logic [FLITS_PER_WORD-1:0] vld;
  logic [FLITS_PER_WORD-1:0] hdr;
  logic [FLITS_PER_WORD-1:0] tail;

  // Placement hits in the current word
  logic hit_a;
  logic hit_b;
  logic start_c;
  logic start_d;
  logic end_c;
  logic end_d;

  // Partial response held across words
  pend_t               pend_q;
  logic [SPAN_C_W-1:0] part_data_q;
  hmc_tag_t            part_tag_q;

  // ----------------------------------------------------------------------
  // Flag decode
  // ----------------------------------------------------------------------

  assign rx_fire = rx.valid && rx_ready_q;
  assign vld     = rx.user[USER_VLD_LSB +: FLITS_PER_WORD];
  assign hdr     = rx.user[USER_HDR_LSB +: FLITS_PER_WORD];
  assign tail    = rx.user[USER_TAIL_LSB +: FLITS_PER_WORD];

  // Whole response in FLITs 0..2
  assign hit_a   = (vld[2:0] == 3'b111) && (hdr[2:0] == 3'b001) && (tail[2:0] == 3'b100);
  // Whole response in FLITs 1..3
  assign hit_b   = (vld[3:1] == 3'b111) && (hdr[3:1] == 3'b001) && (tail[3:1] == 3'b100);
  // Header in FLIT2, no tail yet
  assign start_c = (vld[3:2] == 2'b11) && (hdr[3:2] == 2'b01) && (tail[3:2] == 2'b00);
  // Header in FLIT3, no tail yet
  assign start_d = vld[3] && hdr[3] && !tail[3];
  // Tail in FLIT0 closes a FLIT2 start
  assign end_c   = (pend_q == PEND_C) && vld[0] && !hdr[0] && tail[0];
  // Tail in FLIT1 closes a FLIT3 start
  assign end_d   = (pend_q == PEND_D) && (vld[1:0] == 2'b11) && (hdr[1:0] == 2'b00) &&
                   (tail[1:0] == 2'b10);

  // ----------------------------------------------------------------------
  // Control state
  // ----------------------------------------------------------------------

  always_ff @(posedge CLK) begin
    if (RST) begin
      rx_ready_q  <= 1'b0;
      rsp_valid_o <= 1'b0;
      pend_q      <= PEND_NONE;
    end else begin
      // Never back-pressure once out of reset
      rx_ready_q  <= 1'b1;
      rsp_valid_o <= rx_fire && (hit_a || hit_b || end_c || end_d);
      // Pending state follows accepted words only
      if (rx_fire) begin
        if (start_c) begin
          pend_q <= PEND_C;
        end else if (start_d) begin
          pend_q <= PEND_D;
        end else begin
          pend_q <= PEND_NONE;
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // Payload and tag
  // ----------------------------------------------------------------------

  always_ff @(posedge CLK) begin
    if (rx_fire) begin
      // Completed response, a continuation first
      if (end_d) begin
        rsp_data_o <= {rx.data[0 +: MEM_DATA_W - SPAN_D_W], part_data_q[SPAN_D_W-1:0]};
        rsp_tag_o  <= part_tag_q;
      end else if (end_c) begin
        rsp_data_o <= {rx.data[0 +: MEM_DATA_W - SPAN_C_W], part_data_q};
        rsp_tag_o  <= part_tag_q;
      end else if (hit_b) begin
        rsp_data_o <= rx.data[FLIT_W + HDR_W +: MEM_DATA_W];
        rsp_tag_o  <= rx.data[FLIT_W + HDR_TAG_LSB +: HMC_TAG_W];
      end else if (hit_a) begin
        rsp_data_o <= rx.data[HDR_W +: MEM_DATA_W];
        rsp_tag_o  <= rx.data[HDR_TAG_LSB +: HMC_TAG_W];
      end
      // New spanning response, first part of the payload
      if (start_c) begin
        part_data_q <= rx.data[2 * FLIT_W + HDR_W +: SPAN_C_W];
        part_tag_q  <= rx.data[2 * FLIT_W + HDR_TAG_LSB +: HMC_TAG_W];
      end else if (start_d) begin
        part_data_q[SPAN_D_W-1:0] <= rx.data[3 * FLIT_W + HDR_W +: SPAN_D_W];
        part_tag_q                <= rx.data[3 * FLIT_W + HDR_TAG_LSB +: HMC_TAG_W];
      end
    end
  end

  assign rx.ready = rx_ready_q;

endmodule

// ==== test/hmc_link_model.sv ====
// HMC link and memory model
`timescale 1ns/1ns

module hmc_link_model import hmc_flit_pkg::*; (
  input  logic       CLK,
  input  logic       RST,
  // Transmit stall request and response placement from the testbench
  input  logic       stall_i,
  input  logic [1:0] placement_i,
  // Request stream from the DUT
  input  logic       tx_valid_i,
  output logic       tx_ready_o,
  input  axi_word_t  tx_data_i,
  input  axi_user_t  tx_user_i,
  // Response stream to the DUT
  output logic       rx_valid_o,
  input  logic       rx_ready_i,
  output axi_word_t  rx_data_o,
  output axi_user_t  rx_user_o
);

  // Read response command code
  localparam logic [5:0] CMD_RD_RS = 6'b111000;

  // Written blocks searched by address
  hmc_addr_t mem_addr_q[$];
  mem_data_t mem_data_q[$];
  // Response words waiting for the receive stream
  axi_word_t out_data_q[$];
  axi_user_t out_user_q[$];
  logic      rx_taken;

  initial begin
    rx_valid_o = 1'b0;
    rx_data_o  = '0;
    rx_user_o  = '0;
    rx_taken   = 1'b0;
  end

  assign tx_ready_o = !stall_i;

  // Never written blocks read as zero
  function automatic mem_data_t read_mem(hmc_addr_t addr);
    mem_data_t val;
    val = '0;
    foreach (mem_addr_q[i]) begin
      if (mem_addr_q[i] == addr) begin
        val = mem_data_q[i];
      end
    end
    return val;
  endfunction

  task automatic write_mem(input hmc_addr_t addr, input mem_data_t data);
    int idx;
    idx = -1;
    foreach (mem_addr_q[i]) begin
      if (mem_addr_q[i] == addr) begin
        idx = i;
      end
    end
    if (idx < 0) begin
      mem_addr_q.push_back(addr);
      mem_data_q.push_back(data);
    end else begin
      mem_data_q[idx] = data;
    end
  endtask

  // ----------------------------------------------------------------------
  // Response framing
  // ----------------------------------------------------------------------

  // Three FLIT packet shifted to its start FLIT across one or two words
  task automatic queue_response(input hmc_tag_t tag, input mem_data_t data, input int pos);
    logic [HDR_W-1:0]        hdr;
    logic [3*FLIT_W-1:0]     pkt;
    logic [2*AXI_DATA_W-1:0] span;
    logic [7:0]              vld;
    logic [7:0]              hdr_m;
    logic [7:0]              tail_m;
    hdr        = '0;
    hdr[5:0]   = CMD_RD_RS;
    hdr[10:7]  = LNG_RD_RS;
    hdr[14:11] = LNG_RD_RS;
    hdr[23:15] = tag;
    // Zero tail above the payload
    pkt    = {{HDR_W{1'b0}}, data, hdr};
    span   = {{(AXI_DATA_W + FLIT_W){1'b0}}, pkt};
    span   = span << (pos * FLIT_W);
    vld    = 8'b0000_0111 << pos;
    hdr_m  = 8'b0000_0001 << pos;
    tail_m = 8'b0000_0100 << pos;
    out_data_q.push_back(span[AXI_DATA_W-1:0]);
    out_user_q.push_back({52'b0, tail_m[3:0], hdr_m[3:0], vld[3:0]});
    // Unused FLITs of the second word stay zero and invalid
    if (pos >= 2) begin
      out_data_q.push_back(span[2*AXI_DATA_W-1:AXI_DATA_W]);
      out_user_q.push_back({52'b0, tail_m[7:4], hdr_m[7:4], vld[7:4]});
    end
  endtask

  // ----------------------------------------------------------------------
  // Request decode and response drive
  // ----------------------------------------------------------------------

  // Only a word flagged with a header in FLIT0 carries a request
  always @(posedge CLK) begin
    rx_taken = rx_valid_o && rx_ready_i;
    if (!RST && tx_valid_i && tx_ready_o && tx_user_i[USER_HDR_LSB]) begin
      if (tx_data_i[HDR_CMD_LSB +: HDR_CMD_W] == CMD_P_WR32) begin
        write_mem(tx_data_i[HDR_ADDR_LSB + BLOCK_SHIFT +: HMC_ADDR_W],
                  tx_data_i[HDR_W +: MEM_DATA_W]);
      end else if (tx_data_i[HDR_CMD_LSB +: HDR_CMD_W] == CMD_RD32) begin
        queue_response(tx_data_i[HDR_TAG_LSB +: HMC_TAG_W],
                       read_mem(tx_data_i[HDR_ADDR_LSB + BLOCK_SHIFT +: HMC_ADDR_W]),
                       int'(placement_i));
      end
    end
  end

  // Next word once the current one has gone
  always @(negedge CLK) begin
    if (RST) begin
      rx_valid_o <= 1'b0;
      out_data_q.delete();
      out_user_q.delete();
    end else if (!rx_valid_o || rx_taken) begin
      if (out_data_q.size() > 0) begin
        rx_valid_o <= 1'b1;
        rx_data_o  <= out_data_q.pop_front();
        rx_user_o  <= out_user_q.pop_front();
      end else begin
        rx_valid_o <= 1'b0;
        rx_data_o  <= '0;
        rx_user_o  <= '0;
      end
    end
  end

endmodule

// ==== test/hmc_mem_port_tb.sv ====
// HMC memory port testbench
`timescale 1ns/1ns

module hmc_mem_port_tb import hmc_flit_pkg::*; ();

  localparam int STARTUP_WAIT = 20;
  // All tests together take a few hundred cycles
  localparam int TIMEOUT_CYCLES = 4000;
  // FLITs 0..2 valid, header in 0, tail in 2
  localparam axi_user_t WR_USER = 64'h417;
  // FLIT0 valid, header and tail
  localparam axi_user_t RD_USER = 64'h111;
  localparam hmc_addr_t FMT_ADDR = 27'h1234567;

  logic      CLK;
  logic      RST;
  logic      post_done;
  logic      tx_valid;
  logic      tx_ready;
  axi_word_t tx_data;
  axi_user_t tx_user;
  logic      rx_valid;
  logic      rx_ready;
  axi_word_t rx_data;
  axi_user_t rx_user;
  logic      wr_req;
  hmc_addr_t wr_addr;
  mem_data_t wr_data;
  logic      wr_ready;
  logic      rd_req;
  hmc_addr_t rd_addr;
  hmc_tag_t  rd_tag;
  logic      rd_ready;
  mem_data_t rsp_data;
  hmc_tag_t  rsp_tag;
  logic      rsp_valid;

  logic        stall_en;
  logic        stall;
  logic [1:0]  placement;
  logic [15:0] stall_lfsr;
  logic [15:0] data_lfsr;
  int          cycle_cnt;
  int          tests;
  int          errors;
  int          test_errs;
  string       test_name;
  mem_data_t   fmt_data;

  // Expected words logged at acceptance and seen words at transfer
  axi_word_t exp_data_q[$];
  axi_user_t exp_user_q[$];
  axi_word_t got_data_q[$];
  axi_user_t got_user_q[$];
  mem_data_t rsp_data_q[$];
  hmc_tag_t  rsp_tag_q[$];

  hmc_mem_port #(
    .STARTUP_WAIT_CYCLES (STARTUP_WAIT)
  ) hmc_mem_port_i (
    .CLK          (CLK),
    .RST          (RST),
    .post_done_i  (post_done),
    .tx_valid_o   (tx_valid),
    .tx_ready_i   (tx_ready),
    .tx_data_o    (tx_data),
    .tx_user_o    (tx_user),
    .rx_valid_i   (rx_valid),
    .rx_ready_o   (rx_ready),
    .rx_data_i    (rx_data),
    .rx_user_i    (rx_user),
    .wr_req_i     (wr_req),
    .wr_addr_i    (wr_addr),
    .wr_data_i    (wr_data),
    .wr_ready_o   (wr_ready),
    .rd_req_i     (rd_req),
    .rd_addr_i    (rd_addr),
    .rd_tag_i     (rd_tag),
    .rd_ready_o   (rd_ready),
    .data_o       (rsp_data),
    .tag_o        (rsp_tag),
    .data_valid_o (rsp_valid)
  );

  hmc_link_model link_model_i (
    .CLK         (CLK),
    .RST         (RST),
    .stall_i     (stall),
    .placement_i (placement),
    .tx_valid_i  (tx_valid),
    .tx_ready_o  (tx_ready),
    .tx_data_i   (tx_data),
    .tx_user_i   (tx_user),
    .rx_valid_o  (rx_valid),
    .rx_ready_i  (rx_ready),
    .rx_data_o   (rx_data),
    .rx_user_o   (rx_user)
  );

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  // ----------------------------------------------------------------------
  // Random source and expected encoding
  // ----------------------------------------------------------------------

  // Galois form of x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] next_lfsr(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic rand_bits(input int n, output logic [255:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      val[i]    = data_lfsr[0];
      data_lfsr = next_lfsr(data_lfsr);
    end
  endtask

  // Request word as the encoding rules lay it out
  function automatic axi_word_t expect_word(input logic is_wr, input hmc_addr_t addr,
                                            input hmc_tag_t tag, input mem_data_t data);
    logic [63:0] hdr;
    hdr        = '0;
    hdr[5:0]   = is_wr ? CMD_P_WR32 : CMD_RD32;
    hdr[10:7]  = is_wr ? LNG_P_WR32 : LNG_RD32;
    hdr[14:11] = is_wr ? LNG_P_WR32 : LNG_RD32;
    hdr[23:15] = is_wr ? 9'd0 : tag;
    hdr[57:24] = {2'b00, addr, 5'b00000};
    if (is_wr) begin
      return {128'b0, 64'b0, data, hdr};
    end
    return {448'b0, hdr};
  endfunction

  // One stall decision per cycle
  always @(negedge CLK) begin
    if (stall_en) begin
      stall      = stall_lfsr[0];
      stall_lfsr = next_lfsr(stall_lfsr);
    end else begin
      stall = 1'b0;
    end
  end

  always @(posedge CLK) begin
    if (!RST) begin
      if (wr_req && wr_ready) begin
        exp_data_q.push_back(expect_word(1'b1, wr_addr, 9'd0, wr_data));
        exp_user_q.push_back(WR_USER);
      end else if (rd_req && rd_ready) begin
        exp_data_q.push_back(expect_word(1'b0, rd_addr, rd_tag, '0));
        exp_user_q.push_back(RD_USER);
      end
      if (tx_valid && tx_ready) begin
        got_data_q.push_back(tx_data);
        got_user_q.push_back(tx_user);
      end
      if (rsp_valid) begin
        rsp_data_q.push_back(rsp_data);
        rsp_tag_q.push_back(rsp_tag);
      end
    end
  end

  always @(posedge CLK) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Testbench failed");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------

  task automatic report_mismatch(input string what, input logic [AXI_DATA_W-1:0] exp,
                                 input logic [AXI_DATA_W-1:0] act);
    errors++;
    test_errs++;
    $display("Fail %s %s: expected %0h, actual %0h", test_name, what, exp, act);
  endtask

  task automatic report_problem(input string msg);
    errors++;
    test_errs++;
    $display("Error in %s: %s", test_name, msg);
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_errs = 0;
  endtask

  task automatic finish_test();
    tests++;
    if (test_errs == 0) begin
      $display("%s: ok", test_name);
    end else begin
      $display("%s: %0d errors", test_name, test_errs);
    end
  endtask

  task automatic clear_logs();
    exp_data_q.delete();
    exp_user_q.delete();
    got_data_q.delete();
    got_user_q.delete();
    rsp_data_q.delete();
    rsp_tag_q.delete();
  endtask

  task automatic wait_tx_words(input int n);
    while (got_data_q.size() < n) @(negedge CLK);
  endtask

  task automatic wait_responses(input int n);
    while (rsp_data_q.size() < n) @(negedge CLK);
  endtask

  // Strobe held until the DUT takes it
  task automatic write_request(input hmc_addr_t addr, input mem_data_t data);
    @(negedge CLK);
    wr_req  = 1'b1;
    wr_addr = addr;
    wr_data = data;
    rd_req  = 1'b0;
    @(posedge CLK);
    while (!wr_ready) @(posedge CLK);
    @(negedge CLK);
    wr_req = 1'b0;
  endtask

  task automatic read_request(input hmc_addr_t addr, input hmc_tag_t tag);
    @(negedge CLK);
    rd_req  = 1'b1;
    rd_addr = addr;
    rd_tag  = tag;
    wr_req  = 1'b0;
    @(posedge CLK);
    while (!rd_ready) @(posedge CLK);
    @(negedge CLK);
    rd_req = 1'b0;
  endtask

  // ----------------------------------------------------------------------
  // Tests
  // ----------------------------------------------------------------------

  // Hold-off with a gap in post_done that the count must survive
  task automatic startup_holdoff();
    int  done_cnt;
    logic up_exp;
    logic pd;
    start_test("startup");
    @(negedge CLK);
    if (tx_valid !== 1'b0) report_mismatch("tx_valid in reset", 0, tx_valid);
    if (wr_ready !== 1'b0) report_mismatch("wr_ready in reset", 0, wr_ready);
    if (rd_ready !== 1'b0) report_mismatch("rd_ready in reset", 0, rd_ready);
    if (rsp_valid !== 1'b0) report_mismatch("data_valid in reset", 0, rsp_valid);
    if (rx_ready !== 1'b0) report_mismatch("rx_ready in reset", 0, rx_ready);
    RST = 1'b0;
    @(negedge CLK);
    if (rx_ready !== 1'b1) report_mismatch("rx_ready after reset", 1, rx_ready);
    done_cnt = 0;
    up_exp   = 1'b0;
    for (int i = 0; i < 32; i++) begin
      if (i > 0) begin
        @(negedge CLK);
      end
      if (wr_ready !== up_exp) report_mismatch($sformatf("wr_ready cycle %0d", i), up_exp,
                                               wr_ready);
      if (rd_ready !== up_exp) report_mismatch($sformatf("rd_ready cycle %0d", i), up_exp,
                                               rd_ready);
      pd        = !(i >= 6 && i < 10);
      post_done = pd;
      // What the coming edge does to the DUT
      if (done_cnt == STARTUP_WAIT) begin
        up_exp = 1'b1;
      end
      if (pd && done_cnt < STARTUP_WAIT) begin
        done_cnt++;
      end
    end
    finish_test();
  endtask

  task automatic write_format();
    logic [255:0] r;
    axi_word_t    exp;
    start_test("write_format");
    clear_logs();
    rand_bits(256, r);
    fmt_data = r;
    exp      = expect_word(1'b1, FMT_ADDR, 9'd0, fmt_data);
    write_request(FMT_ADDR, fmt_data);
    wait_tx_words(1);
    repeat (8) @(negedge CLK);
    if (got_data_q.size() != 1) begin
      report_problem($sformatf("%0d transmit words for one write", got_data_q.size()));
    end else begin
      if (got_data_q[0] !== exp) report_mismatch("word", exp, got_data_q[0]);
      if (got_user_q[0] !== WR_USER) report_mismatch("user", WR_USER, got_user_q[0]);
    end
    finish_test();
  endtask

  // Reads back the block written by the format test
  task automatic read_format();
    axi_word_t exp;
    start_test("read_format");
    clear_logs();
    exp = expect_word(1'b0, FMT_ADDR, 9'h15A, '0);
    read_request(FMT_ADDR, 9'h15A);
    wait_tx_words(1);
    wait_responses(1);
    repeat (8) @(negedge CLK);
    if (got_data_q.size() != 1) begin
      report_problem($sformatf("%0d transmit words for one read", got_data_q.size()));
    end else begin
      if (got_data_q[0] !== exp) report_mismatch("word", exp, got_data_q[0]);
      if (got_user_q[0] !== RD_USER) report_mismatch("user", RD_USER, got_user_q[0]);
    end
    if (rsp_data_q.size() != 1) begin
      report_problem($sformatf("%0d responses for one read", rsp_data_q.size()));
    end else begin
      if (rsp_data_q[0] !== fmt_data) report_mismatch("data", fmt_data, rsp_data_q[0]);
      if (rsp_tag_q[0] !== 9'h15A) report_mismatch("tag", 9'h15A, rsp_tag_q[0]);
    end
    finish_test();
  endtask

  task automatic readback_placements();
    hmc_addr_t    addr_tab[7];
    mem_data_t    data_tab[7];
    logic [255:0] r;
    hmc_tag_t     tag;
    start_test("readback");
    for (int i = 0; i < 6; i++) begin
      rand_bits(24, r);
      // Low bits keep the addresses distinct
      addr_tab[i] = {r[23:0], 3'(i)};
      rand_bits(256, r);
      data_tab[i] = r;
      write_request(addr_tab[i], data_tab[i]);
    end
    // Never written
    addr_tab[6] = '1;
    data_tab[6] = '0;
    for (int p = 0; p < 4; p++) begin
      @(negedge CLK);
      placement = 2'(p);
      clear_logs();
      for (int k = 0; k < 7; k++) begin
        read_request(addr_tab[k], 9'(p * 16 + k + 1));
      end
      wait_responses(7);
      repeat (8) @(negedge CLK);
      if (rsp_data_q.size() != 7) begin
        report_problem($sformatf("placement %0d gave %0d responses for 7 reads", p,
                                 rsp_data_q.size()));
      end
      for (int k = 0; k < 7 && k < rsp_data_q.size(); k++) begin
        tag = 9'(p * 16 + k + 1);
        if (rsp_data_q[k] !== data_tab[k]) begin
          report_mismatch($sformatf("data p%0d r%0d", p, k), data_tab[k], rsp_data_q[k]);
        end
        if (rsp_tag_q[k] !== tag) begin
          report_mismatch($sformatf("tag p%0d r%0d", p, k), tag, rsp_tag_q[k]);
        end
      end
    end
    finish_test();
  endtask

  // Random request mix under random transmit stalls
  task automatic backpressure_burst();
    logic [255:0] r;
    logic [255:0] d;
    int           n_reads;
    start_test("backpressure");
    clear_logs();
    n_reads = 0;
    @(posedge CLK);
    stall_en = 1'b1;
    for (int i = 0; i < 20; i++) begin
      rand_bits(28, r);
      if (r[27]) begin
        rand_bits(256, d);
        write_request(r[26:0], d);
      end else begin
        rand_bits(9, d);
        read_request(r[26:0], d[8:0]);
        n_reads++;
      end
    end
    @(posedge CLK);
    stall_en = 1'b0;
    wait_tx_words(20);
    wait_responses(n_reads);
    repeat (8) @(negedge CLK);
    if (got_data_q.size() != exp_data_q.size()) begin
      report_problem($sformatf("%0d transmit words for %0d accepted requests",
                               got_data_q.size(), exp_data_q.size()));
    end
    for (int i = 0; i < exp_data_q.size() && i < got_data_q.size(); i++) begin
      if (got_data_q[i] !== exp_data_q[i]) begin
        report_mismatch($sformatf("word %0d", i), exp_data_q[i], got_data_q[i]);
      end
      if (got_user_q[i] !== exp_user_q[i]) begin
        report_mismatch($sformatf("user %0d", i), exp_user_q[i], got_user_q[i]);
      end
    end
    finish_test();
  endtask

  initial begin
    RST        = 1'b1;
    post_done  = 1'b0;
    wr_req     = 1'b0;
    wr_addr    = '0;
    wr_data    = '0;
    rd_req     = 1'b0;
    rd_addr    = '0;
    rd_tag     = '0;
    stall_en   = 1'b0;
    stall      = 1'b0;
    placement  = 2'd0;
    stall_lfsr = 16'd78;
    data_lfsr  = 16'd78;
    cycle_cnt  = 0;
    tests      = 0;
    errors     = 0;
    repeat (10) @(posedge CLK);
    startup_holdoff();
    write_format();
    read_format();
    readback_placements();
    backpressure_burst();
    $display("Tests run: %0d, errors: %0d", tests, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule
